//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary -f verilog.f --top-module tb_cd_sys -Mdir obj_dir -o sim_cd_sys
	@out="$$(./obj_dir/sim_cd_sys)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- dv/cd_sys_cases.txt
// microcode  addr_a  addr_b  fill_value  count  area  map_mask
// map_mask bits 3 to 0 map sprite, PCM, Z80 and fix
FFCD E00000 000000 1234 4 0 8
FE6D 100000 E40010 0000 3 1 4
F2DD 120100 E80000 0000 3 5 1
FFDD 200000 000000 BEEF 5 4 2
FE3D 0FFFFC E20000 0000 4 0 7
E2DD 3000F0 E60000 0000 2 4 2
0000 140000 E00100 0000 2 5 F
FFCD E10000 000000 00FF 1 1 0
FE6D E30000 500000 0000 2 0 F
FFDD EF0000 000000 5A5A 6 5 1

//--- dv/cd_sys_checker.sv
`timescale 1ns/1ns

module cd_sys_checker
	import cd_host_pkg::*;
	import cd_dma_pkg::*;
(
	input  logic        clk_sys,
	input  logic        nRESET,
	input  dma_bus_t    dma,
	input  logic        nbr,
	input  logic        nbgack,
	input  cpu_bus_t    cpu,
	input  logic [3:0]  tr_wr,       // Sprite, PCM, Z80, fix
	input  logic [15:0] tr_wr_data,
	input  logic [19:1] tr_wr_addr,
	input  upload_ctl_t upload_ctl,
	input  video_ctl_t  video_ctl,
	input  logic        ctl_check,
	input  upload_ctl_t exp_upload,
	input  video_ctl_t  exp_video,
	input  logic [15:0] exp_tr_data,
	input  logic [19:1] exp_tr_addr,
	input  logic        job_load,
	input  logic [15:0] job_mc,
	input  logic [23:0] job_a,
	input  logic [23:0] job_b,
	input  logic [15:0] job_value,
	input  logic [23:0] job_count,
	output int          err_count
);

	logic [39:0] exp_q [$];  // Write address and data, in order
	logic [1:0] last_mode;    // 0 fill, 1 word copy, 2 byte copy
	logic running_prev, nbr_seen;

	// Same formula as the read model in the testbench
	function automatic logic [15:0] src_word(input logic [23:0] addr);
		return addr[15:0] ^ 16'hA5A5;
	endfunction

	function automatic logic [1:0] mode_of(input logic [15:0] mc, input logic [1:0] prev);
		case (mc)
			16'hFE6D, 16'hFE3D: return 2'd1;
			16'hF2DD, 16'hE2DD: return 2'd2;
			16'hFFCD, 16'hFFDD: return 2'd0;
			default:            return prev;
		endcase
	endfunction

	function automatic logic [3:0] strobes_for(input logic [23:0] addr, input upload_ctl_t uc);
		logic [3:0] sel;
		sel = 4'b0000;
		if (addr[23:20] == 4'hE)
		begin
			case (uc.area)
				3'd0:    sel = {uc.use_spr, 3'b000};
				3'd1:    sel = {1'b0, uc.use_pcm, 2'b00};
				3'd4:    sel = {2'b00, uc.use_z80, 1'b0};
				3'd5:    sel = {3'b000, uc.use_fix};
				default: sel = 4'b0000;
			endcase
		end
		return sel;
	endfunction

	// ============================================================
	// Sampled on the falling edge, away from every update
	// ============================================================
	always @(negedge clk_sys)
	begin
		logic [39:0] want;
		logic [3:0] want_str;
		logic [23:0] src, dst;
		logic [15:0] w;
		int i;
		if (!nRESET)
		begin
			err_count = 0;
			last_mode = 2'd0;
			running_prev = 1'b0;
			nbr_seen = 1'b0;
			exp_q.delete();
		end
		else
		begin
			want_str = 4'b0000;
			// CPU writes reach the upload strobes while no DMA runs
			if (!dma.running && !cpu.rw && !(cpu.nlds && cpu.nuds))
				want_str = strobes_for({cpu.addr, 1'b0}, exp_upload);
			if (ctl_check)
			begin
				if (upload_ctl !== exp_upload)
				begin
					$display("ERR upload_ctl expected %h got %h", exp_upload, upload_ctl);
					err_count = err_count + 1;
				end
				if (video_ctl !== exp_video)
				begin
					$display("ERR video_ctl expected %h got %h", exp_video, video_ctl);
					err_count = err_count + 1;
				end
			end
			if (job_load)
			begin
				if (tr_wr_data !== exp_tr_data)
				begin
					$display("ERR tr_wr_data expected %h got %h", exp_tr_data, tr_wr_data);
					err_count = err_count + 1;
				end
				if (tr_wr_addr !== exp_tr_addr)
				begin
					$display("ERR tr_wr_addr expected %h got %h", exp_tr_addr, tr_wr_addr);
					err_count = err_count + 1;
				end
				last_mode = mode_of(job_mc, last_mode);
				exp_q.delete();
				src = job_a;
				dst = job_b;
				for (i = 0; i < int'(job_count); i++)
				begin
					w = src_word(src);
					case (last_mode)
						2'd0: exp_q.push_back({src, job_value});  // Fill writes at A
						2'd1: exp_q.push_back({dst + 24'd0, w});
						default:
						begin
							exp_q.push_back({dst, w[7:0], w[15:8]});
							exp_q.push_back({dst + 24'd2, w});
						end
					endcase
					src = src + 24'd2;
					dst = dst + ((last_mode == 2'd2) ? 24'd4 : 24'd2);
				end
			end
			if ((dma.wr || dma.rd) && nbgack)
			begin
				$display("DMA bus access at %0t while the bus was not acknowledged", $time);
				err_count = err_count + 1;
			end
			if (!nbr)
				nbr_seen = 1'b1;
			if (!nbgack && !nbr_seen)
			begin
				$display("Bus acknowledged at %0t before it was requested", $time);
				err_count = err_count + 1;
			end
			if (dma.wr)
			begin
				if (exp_q.size() == 0)
				begin
					$display("Unexpected DMA write at %0t to %h", $time, dma.addr_out);
					err_count = err_count + 1;
				end
				else
				begin
					want = exp_q.pop_front();
					want_str = strobes_for(want[39:16], exp_upload);
					if (dma.addr_out !== want[39:16])
					begin
						$display("ERR dma.addr_out expected %h got %h", want[39:16], dma.addr_out);
						err_count = err_count + 1;
					end
					if (dma.data_out !== want[15:0])
					begin
						$display("ERR dma.data_out expected %h got %h", want[15:0], dma.data_out);
						err_count = err_count + 1;
					end
				end
			end
			if (tr_wr !== want_str)
			begin
				$display("ERR tr_wr expected %h got %h", want_str, tr_wr);
				err_count = err_count + 1;
			end
			if (running_prev && !dma.running)
			begin
				if (!nbgack || !nbr)
				begin
					$display("Bus not handed back when the DMA job ended at %0t", $time);
					err_count = err_count + 1;
				end
				if (exp_q.size() != 0)
				begin
					$display("DMA job ended with %0d writes missing", exp_q.size());
					err_count = err_count + 1;
				end
				nbr_seen = 1'b0;
			end
			running_prev = dma.running;
		end
	end

endmodule

//--- dv/tb_cd_sys.sv
`timescale 1ns/1ns

module tb_cd_sys
	import cd_host_pkg::*;
	import cd_dma_pkg::*;
();

	localparam int RD_WAIT = 12;
	localparam int WR_WAIT = 10;
	localparam int COLS = 7;       // Words per case line
	localparam int MAX_JOBS = 16;

	logic clk_sys = 1'b0;
	logic nRESET;
	cpu_bus_t cpu;
	logic cpu_clk_en = 1'b0;
	logic system_cdx;
	logic nbg = 1'b1;
	logic [15:0] dma_data_in = 16'h0000;
	logic dma_sdram_busy = 1'b0;
	logic nbr, nbgack;
	dma_bus_t dma;
	upload_ctl_t upload_ctl;
	video_ctl_t video_ctl;
	logic tr_wr_spr, tr_wr_pcm, tr_wr_z80, tr_wr_fix;
	logic [15:0] tr_wr_data;
	logic [19:1] tr_wr_addr;

	// Job and control values handed to the checker
	logic job_load = 1'b0;
	logic ctl_check = 1'b0;
	logic [15:0] job_mc, job_value;
	logic [23:0] job_a, job_b, job_count;
	upload_ctl_t exp_upload;
	video_ctl_t exp_video;
	logic [15:0] exp_tr_data;
	logic [19:1] exp_tr_addr;
	int err_count;

	logic [31:0] cases_mem [0:MAX_JOBS*COLS-1];
	int num_jobs;
	int file_errors = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int grant_wait = 0;
	logic grant_armed = 1'b0;
	int busy_left = 0;

	always #2 clk_sys = ~clk_sys;

	cd_sys #(.COUNT_W(24), .RD_WAIT(RD_WAIT), .WR_WAIT(WR_WAIT)) u_cd_sys (
		.clk_sys(clk_sys), .nRESET(nRESET), .cpu(cpu),
		.cpu_clk_en(cpu_clk_en), .system_cdx(system_cdx), .nbg(nbg),
		.dma_data_in(dma_data_in), .dma_sdram_busy(dma_sdram_busy),
		.nbr(nbr), .nbgack(nbgack), .dma(dma),
		.upload_ctl(upload_ctl), .video_ctl(video_ctl),
		.tr_wr_spr(tr_wr_spr), .tr_wr_pcm(tr_wr_pcm),
		.tr_wr_z80(tr_wr_z80), .tr_wr_fix(tr_wr_fix),
		.tr_wr_data(tr_wr_data), .tr_wr_addr(tr_wr_addr)
	);

	cd_sys_checker u_checker (
		.clk_sys(clk_sys), .nRESET(nRESET), .dma(dma), .nbr(nbr), .nbgack(nbgack),
		.cpu(cpu),
		.tr_wr({tr_wr_spr, tr_wr_pcm, tr_wr_z80, tr_wr_fix}),
		.tr_wr_data(tr_wr_data), .tr_wr_addr(tr_wr_addr),
		.upload_ctl(upload_ctl), .video_ctl(video_ctl),
		.ctl_check(ctl_check), .exp_upload(exp_upload), .exp_video(exp_video),
		.exp_tr_data(exp_tr_data), .exp_tr_addr(exp_tr_addr),
		.job_load(job_load), .job_mc(job_mc), .job_a(job_a), .job_b(job_b),
		.job_value(job_value), .job_count(job_count), .err_count(err_count)
	);

	// ============================================================
	// CPU enable, bus grant, SDRAM and read data models
	// ============================================================
	always @(posedge clk_sys)
	begin
		#1;
		cpu_clk_en <= ~cpu_clk_en;
		dma_data_in <= dma.addr_in[15:0] ^ 16'hA5A5;
		if (!nbgack)
		begin
			nbg <= 1'b1;  // DMA owns the bus now
			grant_armed = 1'b0;
		end
		else if (nRESET && !nbr && nbg)
		begin
			if (!grant_armed)
			begin
				grant_armed = 1'b1;
				grant_wait = $urandom_range(1, 8);
			end
			grant_wait = grant_wait - 1;
			if (grant_wait == 0)
				nbg <= 1'b0;
		end
		if (busy_left != 0)
			busy_left = busy_left - 1;
		else if ($urandom_range(0, 5) == 0)
			busy_left = $urandom_range(0, 3);  // Short refresh burst
		dma_sdram_busy <= (busy_left != 0);
	end

	always @(posedge clk_sys)
	begin
		cycles = cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit)
		begin
			$display("Run stopped at cycle %0d, a DMA job did not finish in time", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	// One CPU write, strobes low across one enable then high across one
	task automatic cpu_write(input logic [23:1] addr, input logic [15:0] data, input logic word);
		@(posedge clk_sys);
		#1;
		cpu.addr = addr;
		cpu.data = data;
		cpu.rw = 1'b0;
		cpu.nas = 1'b0;
		cpu.nlds = 1'b0;
		cpu.nuds = ~word;  // Byte writes use the odd address
		repeat (2) @(posedge clk_sys);
		#1;
		cpu.rw = 1'b1;
		cpu.nas = 1'b1;
		cpu.nlds = 1'b1;
		cpu.nuds = 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic reg_write(input logic [7:0] offs, input logic [15:0] data, input logic word);
		cpu_write({REG_PAGE, offs}, data, word);
	endtask

	task automatic notify_checker(input logic load);
		@(posedge clk_sys);
		#1;
		ctl_check = 1'b1;
		job_load = load;
		@(posedge clk_sys);
		#1;
		ctl_check = 1'b0;
		job_load = 1'b0;
	endtask

	task automatic run_job(input int base);
		logic [31:0] area, map, rnd, up_rnd;
		video_ctl_t vid;
		job_mc = cases_mem[base][15:0];
		job_a = cases_mem[base+1][23:0];
		job_b = cases_mem[base+2][23:0];
		job_value = cases_mem[base+3][15:0];
		job_count = cases_mem[base+4][23:0];
		area = cases_mem[base+5];
		map = cases_mem[base+6];
		rnd = $urandom;
		up_rnd = $urandom;
		reg_write(REG_ADDR_A_HI, {8'h00, job_a[23:16]}, 1'b1);
		reg_write(REG_ADDR_A_LO, job_a[15:0], 1'b1);
		reg_write(REG_ADDR_B_HI, {8'h00, job_b[23:16]}, 1'b1);
		reg_write(REG_ADDR_B_LO, job_b[15:0], 1'b1);
		reg_write(REG_VALUE_HI, job_value, 1'b1);
		reg_write(REG_COUNT_HI, {8'h00, job_count[23:16]}, 1'b1);
		reg_write(REG_COUNT_LO, job_count[15:0], 1'b1);
		reg_write(REG_MICROCODE0, job_mc, 1'b1);
		reg_write(REG_AREA_SEL, {13'd0, area[2:0]}, 1'b0);
		reg_write(map[3] ? REG_MAP_SPR : REG_UNMAP_SPR, 16'h0000, 1'b0);
		reg_write(map[2] ? REG_MAP_PCM : REG_UNMAP_PCM, 16'h0000, 1'b0);
		reg_write(map[1] ? REG_MAP_Z80 : REG_UNMAP_Z80, 16'h0000, 1'b0);
		reg_write(map[0] ? REG_MAP_FIX : REG_UNMAP_FIX, 16'h0000, 1'b0);
		reg_write(REG_SPR_DIS, {15'd0, rnd[0]}, 1'b0);
		reg_write(REG_FIX_DIS, {15'd0, rnd[1]}, 1'b0);
		reg_write(REG_VIDEO_EN, {15'd0, rnd[2]}, 1'b0);
		reg_write(REG_Z80_RESET, {15'd0, rnd[3]}, 1'b0);
		reg_write(REG_UPLOAD_EN, {15'd0, rnd[4]}, 1'b0);
		reg_write(REG_SPR_BANK, {14'd0, rnd[6:5]}, 1'b0);
		reg_write(REG_PCM_BANK, {15'd0, rnd[7]}, 1'b0);
		vid = '{spr_en: ~rnd[0], fix_en: ~rnd[1], video_en: rnd[2], nreset_z80: rnd[3],
			upload_en: rnd[4], spr_bank: rnd[6:5], pcm_bank: rnd[7]};
		exp_upload = '{area: area[2:0], use_spr: map[3], use_pcm: map[2],
			use_z80: map[1], use_fix: map[0]};
		exp_video = vid;
		exp_tr_data = rnd[23:8];
		exp_tr_addr = up_rnd[18:0];
		cpu_write({UPLOAD_ZONE, up_rnd[18:0]}, rnd[23:8], 1'b1);  // Latched upload word
		notify_checker(1'b1);
		reg_write(REG_DMA_START, 16'h0040, 1'b0);
		do @(negedge clk_sys); while (!dma.running);
		do @(negedge clk_sys); while (dma.running);
	endtask

	initial
	begin
		void'($urandom(32'heb880c20));
		nRESET = 1'b0;
		system_cdx = 1'b1;
		cpu = '{addr: '0, data: '0, rw: 1'b1, nas: 1'b1, nlds: 1'b1, nuds: 1'b1, ndtack: 1'b1};
		for (int i = 0; i < MAX_JOBS * COLS; i++)
			cases_mem[i] = '1;  // Marks the end of the jobs
		$readmemh("dv/cd_sys_cases.txt", cases_mem);
		num_jobs = 0;
		while (num_jobs < MAX_JOBS && cases_mem[num_jobs*COLS] != 32'hFFFF_FFFF)
		begin
			cycle_limit = cycle_limit + int'(cases_mem[num_jobs*COLS+4]) * 3 *
				(RD_WAIT + WR_WAIT + 8) + 200;
			num_jobs = num_jobs + 1;
		end
		if (num_jobs == 0)
		begin
			$display("No DMA jobs found in dv/cd_sys_cases.txt");
			file_errors = 1;
		end
		repeat (5) @(posedge clk_sys);
		#1;
		nRESET = 1'b1;
		exp_upload = '0;
		exp_video = '{spr_en: 1'b1, fix_en: 1'b1, video_en: 1'b1, default: '0};
		notify_checker(1'b0);
		for (int j = 0; j < num_jobs; j++)
			run_job(j * COLS);
		repeat (4) @(posedge clk_sys);
		$display("Checks finished with %0d errors", err_count + file_errors);
		if (err_count + file_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- rtl/cd_dma_engine.sv
`timescale 1ns/1ns

module cd_dma_engine
	import cd_dma_pkg::*;
#(
	parameter int COUNT_W = 24,
	parameter int RD_WAIT = 20,
	parameter int WR_WAIT = 20
)
(
	input  logic        clk_sys,
	input  logic        nRESET,
	input  dma_cfg_t    dma_cfg,
	input  logic        dma_start,
	input  logic        nbg,
	input  logic        cpu_nas,
	input  logic        cpu_ndtack,
	input  logic [15:0] dma_data_in,
	input  logic        dma_sdram_busy,
	output dma_bus_t    dma,
	output logic        nbr,
	output logic        nbgack
);

	localparam int WAIT_MAX = (RD_WAIT > WR_WAIT) ? RD_WAIT : WR_WAIT;
	localparam int WAIT_W = (WAIT_MAX < 2) ? 1 : $clog2(WAIT_MAX + 1);

	typedef enum logic [3:0] {
		ST_IDLE, ST_BR, ST_WAIT_BG, ST_WAIT_AS, ST_START,
		ST_RD, ST_RD_DONE, ST_WR, ST_WR_DONE, ST_DONE
	} dma_state_t;

	dma_state_t state;
	logic start_prev, start_rise, step;
	logic [WAIT_W-1:0] timer;
	logic [1:0] io_cnt;  // Access index within one count
	logic running, wr_q, rd_q;

	dma_mode_t mode_q;
	logic [COUNT_W-1:0] count_run;
	logic [23:0] addr_in, addr_out;
	logic [15:0] data_out, rd_data;

	assign start_rise = dma_start & ~start_prev;
	assign step = ~dma_sdram_busy & (timer == '0);

	// ============================================================
	// Bus arbitration and sequencing
	// ============================================================
	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			state <= ST_IDLE;
			start_prev <= 1'b0;
			timer <= '0;
			io_cnt <= 2'd0;
			running <= 1'b0;
			wr_q <= 1'b0;
			rd_q <= 1'b0;
			nbr <= 1'b1;
			nbgack <= 1'b1;
		end
		else
		begin
			start_prev <= dma_start;
			wr_q <= 1'b0;
			rd_q <= 1'b0;
			if (timer != '0)
				timer <= timer - 1'b1;  // Runs even while SDRAM is busy
			if (start_rise)
			begin
				state <= ST_BR;
				running <= 1'b1;
				io_cnt <= 2'd0;
			end
			else if (step)
			begin
				case (state)
					ST_BR:
					begin
						nbr <= 1'b0;
						state <= ST_WAIT_BG;
					end
					ST_WAIT_BG: if (!nbg) state <= ST_WAIT_AS;
					ST_WAIT_AS:
					begin
						// Last CPU cycle must be finished
						if (cpu_nas && cpu_ndtack)
						begin
							nbr <= 1'b1;
							nbgack <= 1'b0;
							state <= ST_START;
						end
					end
					ST_START:
					begin
						if (count_run == '0)
						begin
							state <= ST_IDLE;
							nbgack <= 1'b1;  // Hand the bus back
							running <= 1'b0;
						end
						else
						begin
							case (mode_q)
								DMA_FILL: state <= (io_cnt == 2'd0) ? ST_WR : ST_DONE;
								DMA_COPY_WORD:
									state <= (io_cnt == 2'd0) ? ST_RD :
									         (io_cnt == 2'd1) ? ST_WR : ST_DONE;
								DMA_COPY_BYTE:
									state <= (io_cnt == 2'd0) ? ST_RD :
									         (io_cnt == 2'd3) ? ST_DONE : ST_WR;
								default: state <= ST_DONE;
							endcase
						end
					end
					ST_RD:
					begin
						rd_q <= 1'b1;
						timer <= WAIT_W'(RD_WAIT);
						state <= ST_RD_DONE;
					end
					ST_WR:
					begin
						wr_q <= 1'b1;
						timer <= WAIT_W'(WR_WAIT);
						state <= ST_WR_DONE;
					end
					ST_RD_DONE, ST_WR_DONE:
					begin
						io_cnt <= io_cnt + 2'd1;
						state <= ST_START;
					end
					ST_DONE:
					begin
						io_cnt <= 2'd0;
						state <= ST_START;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// Addresses, data and count
	always_ff @(posedge clk_sys)
	begin
		if (start_rise)
		begin
			mode_q <= dma_cfg.mode;
			count_run <= dma_cfg.count[COUNT_W-1:0];
			if (dma_cfg.mode == DMA_FILL)
			begin
				addr_out <= dma_cfg.addr_a;
				data_out <= dma_cfg.value;
			end
			else
			begin
				addr_in <= dma_cfg.addr_a;
				addr_out <= dma_cfg.addr_b;
			end
		end
		else if (step)
		begin
			case (state)
				ST_START:
				begin
					if (mode_q == DMA_COPY_BYTE && io_cnt == 2'd1)
						data_out <= {rd_data[7:0], rd_data[15:8]};  // Swapped first
					else if (mode_q != DMA_FILL)
						data_out <= rd_data;
				end
				ST_RD_DONE:
				begin
					rd_data <= dma_data_in;
					addr_in <= addr_in + 24'd2;
				end
				ST_WR_DONE: addr_out <= addr_out + 24'd2;
				ST_DONE:    count_run <= count_run - 1'b1;
				default: ;
			endcase
		end
	end

	assign dma = '{running: running, wr: wr_q, rd: rd_q, addr_in: addr_in,
		addr_out: addr_out, data_out: data_out};

endmodule

//--- rtl/cd_dma_pkg.sv
package cd_dma_pkg;

	// Widest count the host can write, two 16-bit words
	localparam int DMA_COUNT_MAX_W = 32;

	typedef enum logic [1:0] {
		DMA_FILL      = 2'd0,
		DMA_COPY_WORD = 2'd1,
		DMA_COPY_BYTE = 2'd2
	} dma_mode_t;

	// Microcode word 0 values seen from the BIOS
	localparam logic [15:0] MC_COPY_WORD_A = 16'hFE6D;
	localparam logic [15:0] MC_COPY_WORD_B = 16'hFE3D;
	localparam logic [15:0] MC_COPY_BYTE_A = 16'hF2DD;
	localparam logic [15:0] MC_COPY_BYTE_B = 16'hE2DD;
	localparam logic [15:0] MC_FILL_A      = 16'hFFCD;
	localparam logic [15:0] MC_FILL_B      = 16'hFFDD;

	typedef struct packed {
		dma_mode_t                  mode;
		logic [23:0]                addr_a;  // Fill target or copy source
		logic [23:0]                addr_b;  // Copy target
		logic [15:0]                value;
		logic [DMA_COUNT_MAX_W-1:0] count;   // In words
	} dma_cfg_t;

	typedef struct packed {
		logic        running;
		logic        wr;
		logic        rd;
		logic [23:0] addr_in;   // Read side
		logic [23:0] addr_out;  // Write side
		logic [15:0] data_out;
	} dma_bus_t;

endpackage

//--- rtl/cd_host_pkg.sv
package cd_host_pkg;

	// ============================================================
	// CPU side bus, sampled as one word
	// ============================================================
	typedef struct packed {
		logic [23:1] addr;    // Word address
		logic [15:0] data;
		logic        rw;      // 1 = read
		logic        nas;
		logic        nlds;
		logic        nuds;
		logic        ndtack;
	} cpu_bus_t;

	// Register page FF00xx/FF01xx on addr[23:9]
	localparam logic [14:0] REG_PAGE = 15'h7F80;
	localparam logic [3:0] UPLOAD_ZONE = 4'hE;

	// Word offsets on addr[8:1], bit 7 picks the FF01xx half
	localparam logic [7:0] REG_DMA_START  = 8'h30;  // FF0061
	localparam logic [7:0] REG_ADDR_A_HI  = 8'h32;
	localparam logic [7:0] REG_ADDR_A_LO  = 8'h33;
	localparam logic [7:0] REG_ADDR_B_HI  = 8'h34;
	localparam logic [7:0] REG_ADDR_B_LO  = 8'h35;
	localparam logic [7:0] REG_VALUE_HI   = 8'h36;
	localparam logic [7:0] REG_COUNT_HI   = 8'h38;
	localparam logic [7:0] REG_COUNT_LO   = 8'h39;
	localparam logic [7:0] REG_MICROCODE0 = 8'h3F;  // FF007E
	localparam logic [7:0] REG_AREA_SEL   = 8'h82;  // FF0105
	localparam logic [7:0] REG_SPR_DIS    = 8'h88;
	localparam logic [7:0] REG_FIX_DIS    = 8'h8A;
	localparam logic [7:0] REG_VIDEO_EN   = 8'h8C;
	localparam logic [7:0] REG_MAP_SPR    = 8'h90;
	localparam logic [7:0] REG_MAP_PCM    = 8'h91;
	localparam logic [7:0] REG_MAP_Z80    = 8'h93;
	localparam logic [7:0] REG_MAP_FIX    = 8'h94;
	localparam logic [7:0] REG_UNMAP_SPR  = 8'hA0;
	localparam logic [7:0] REG_UNMAP_PCM  = 8'hA1;
	localparam logic [7:0] REG_UNMAP_Z80  = 8'hA3;
	localparam logic [7:0] REG_UNMAP_FIX  = 8'hA4;
	localparam logic [7:0] REG_UPLOAD_EN  = 8'hB7;  // FF016F
	localparam logic [7:0] REG_Z80_RESET  = 8'hC1;
	localparam logic [7:0] REG_SPR_BANK   = 8'hD0;
	localparam logic [7:0] REG_PCM_BANK   = 8'hD1;

	localparam logic [2:0] AREA_SPR = 3'd0;
	localparam logic [2:0] AREA_PCM = 3'd1;
	localparam logic [2:0] AREA_Z80 = 3'd4;
	localparam logic [2:0] AREA_FIX = 3'd5;

	typedef struct packed {
		logic [2:0] area;
		logic       use_spr;
		logic       use_pcm;
		logic       use_z80;
		logic       use_fix;
	} upload_ctl_t;

	typedef struct packed {
		logic       spr_en;
		logic       fix_en;
		logic       video_en;
		logic       nreset_z80;
		logic       upload_en;
		logic [1:0] spr_bank;
		logic       pcm_bank;
	} video_ctl_t;

endpackage

//--- rtl/cd_host_regs.sv
`timescale 1ns/1ns

module cd_host_regs
	import cd_host_pkg::*;
	import cd_dma_pkg::*;
#(
	parameter int COUNT_W = 24
)
(
	input  logic        clk_sys,
	input  logic        nRESET,
	input  logic        cpu_clk_en,
	input  logic        system_cdx,
	input  cpu_bus_t    cpu,
	output dma_cfg_t    dma_cfg,
	output logic        dma_start,
	output upload_ctl_t upload_ctl,
	output video_ctl_t  video_ctl,
	output logic [15:0] tr_wr_data,
	output logic [19:1] tr_wr_addr
);

	logic nlds_prev, nuds_prev;
	logic strobe_fall, reg_wr, up_wr;
	logic word_wr, low_wr, start_wr;
	logic [7:0] reg_offs;

	dma_mode_t mode_q;
	logic [23:0] addr_a, addr_b;
	logic [15:0] value_hi, mc0;
	logic [COUNT_W-1:0] count_q;
	logic [DMA_COUNT_MAX_W-1:0] count_wide;

	// ============================================================
	// Write detection on the data strobes
	// ============================================================
	assign strobe_fall = cpu_clk_en & system_cdx &
		((nlds_prev & ~cpu.nlds) | (nuds_prev & ~cpu.nuds));
	assign reg_wr = strobe_fall & ~cpu.rw & (cpu.addr[23:9] == REG_PAGE);
	assign up_wr = strobe_fall & ~cpu.rw & (cpu.addr[23:9] != REG_PAGE) &
		(cpu.addr[23:20] == UPLOAD_ZONE);
	assign reg_offs = cpu.addr[8:1];
	assign word_wr = ~cpu.nuds & ~cpu.nlds;
	assign low_wr = ~cpu.nlds;              // Byte at the odd address
	assign start_wr = cpu.nuds & ~cpu.nlds;  // FF0061 only as a byte
	assign count_wide = DMA_COUNT_MAX_W'(count_q);

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			nlds_prev <= 1'b1;
			nuds_prev <= 1'b1;
			dma_start <= 1'b0;
			mode_q <= DMA_FILL;
			upload_ctl <= '0;
			video_ctl <= '{spr_en: 1'b1, fix_en: 1'b1, video_en: 1'b1, default: '0};
		end
		else
		begin
			if (cpu_clk_en)
			begin
				nlds_prev <= cpu.nlds;
				nuds_prev <= cpu.nuds;
				if (dma_start)
					dma_start <= 1'b0;  // One enable period wide
			end
			if (reg_wr)
			begin
				case (reg_offs)
					REG_DMA_START:
					begin
						if (start_wr && cpu.data[6])
						begin
							dma_start <= 1'b1;
							case (mc0)
								MC_COPY_WORD_A, MC_COPY_WORD_B: mode_q <= DMA_COPY_WORD;
								MC_COPY_BYTE_A, MC_COPY_BYTE_B: mode_q <= DMA_COPY_BYTE;
								MC_FILL_A, MC_FILL_B:           mode_q <= DMA_FILL;
								default: ;  // Test mode microcodes, keep last mode
							endcase
						end
					end
					REG_AREA_SEL:  if (low_wr) upload_ctl.area <= cpu.data[2:0];
					REG_SPR_DIS:   if (low_wr) video_ctl.spr_en <= ~cpu.data[0];
					REG_FIX_DIS:   if (low_wr) video_ctl.fix_en <= ~cpu.data[0];
					REG_VIDEO_EN:  if (low_wr) video_ctl.video_en <= cpu.data[0];
					REG_MAP_SPR:   if (low_wr) upload_ctl.use_spr <= 1'b1;
					REG_MAP_PCM:   if (low_wr) upload_ctl.use_pcm <= 1'b1;
					REG_MAP_Z80:   if (low_wr) upload_ctl.use_z80 <= 1'b1;
					REG_MAP_FIX:   if (low_wr) upload_ctl.use_fix <= 1'b1;
					REG_UNMAP_SPR: if (low_wr) upload_ctl.use_spr <= 1'b0;
					REG_UNMAP_PCM: if (low_wr) upload_ctl.use_pcm <= 1'b0;
					REG_UNMAP_Z80: if (low_wr) upload_ctl.use_z80 <= 1'b0;
					REG_UNMAP_FIX: if (low_wr) upload_ctl.use_fix <= 1'b0;
					REG_UPLOAD_EN: if (low_wr) video_ctl.upload_en <= cpu.data[0];
					REG_Z80_RESET: if (low_wr) video_ctl.nreset_z80 <= cpu.data[0];
					REG_SPR_BANK:  if (low_wr) video_ctl.spr_bank <= cpu.data[1:0];
					REG_PCM_BANK:  if (low_wr) video_ctl.pcm_bank <= cpu.data[0];
					default: ;
				endcase
			end
		end
	end

	// DMA parameters and the upload latch
	always_ff @(posedge clk_sys)
	begin
		if (reg_wr && word_wr)
		begin
			case (reg_offs)
				REG_ADDR_A_HI:  addr_a[23:16] <= cpu.data[7:0];
				REG_ADDR_A_LO:  addr_a[15:0] <= cpu.data;
				REG_ADDR_B_HI:  addr_b[23:16] <= cpu.data[7:0];
				REG_ADDR_B_LO:  addr_b[15:0] <= cpu.data;
				REG_VALUE_HI:   value_hi <= cpu.data;
				REG_COUNT_HI:   count_q <= COUNT_W'({cpu.data, count_wide[15:0]});
				REG_COUNT_LO:   count_q <= COUNT_W'({count_wide[31:16], cpu.data});
				REG_MICROCODE0: mc0 <= cpu.data;
				default: ;
			endcase
		end
		if (up_wr)
		begin
			tr_wr_data <= cpu.data;
			tr_wr_addr <= cpu.addr[19:1];
		end
	end

	assign dma_cfg = '{mode: mode_q, addr_a: addr_a, addr_b: addr_b,
		value: value_hi, count: count_wide};

endmodule

//--- rtl/cd_sys.sv
`timescale 1ns/1ns

module cd_sys
	import cd_host_pkg::*;
	import cd_dma_pkg::*;
#(
	parameter int COUNT_W = 24,
	parameter int RD_WAIT = 20,
	parameter int WR_WAIT = 20
)
(
	input  logic        clk_sys,
	input  logic        nRESET,
	input  cpu_bus_t    cpu,
	input  logic        cpu_clk_en,
	input  logic        system_cdx,
	input  logic        nbg,
	input  logic [15:0] dma_data_in,
	input  logic        dma_sdram_busy,
	output logic        nbr,
	output logic        nbgack,
	output dma_bus_t    dma,
	output upload_ctl_t upload_ctl,
	output video_ctl_t  video_ctl,
	output logic        tr_wr_spr,
	output logic        tr_wr_pcm,
	output logic        tr_wr_z80,
	output logic        tr_wr_fix,
	output logic [15:0] tr_wr_data,
	output logic [19:1] tr_wr_addr
);

	dma_cfg_t dma_cfg;
	logic dma_start;

	cd_host_regs #(.COUNT_W(COUNT_W)) u_host_regs (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.cpu_clk_en(cpu_clk_en), .system_cdx(system_cdx), .cpu(cpu),
		.dma_cfg(dma_cfg), .dma_start(dma_start),
		.upload_ctl(upload_ctl), .video_ctl(video_ctl),
		.tr_wr_data(tr_wr_data), .tr_wr_addr(tr_wr_addr)
	);

	cd_dma_engine #(.COUNT_W(COUNT_W), .RD_WAIT(RD_WAIT), .WR_WAIT(WR_WAIT)) u_dma_engine (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.dma_cfg(dma_cfg), .dma_start(dma_start),
		.nbg(nbg), .cpu_nas(cpu.nas), .cpu_ndtack(cpu.ndtack),
		.dma_data_in(dma_data_in), .dma_sdram_busy(dma_sdram_busy),
		.dma(dma), .nbr(nbr), .nbgack(nbgack)
	);

	cd_upload_decode u_upload_decode (
		.cpu(cpu), .dma(dma), .upload_ctl(upload_ctl),
		.tr_wr_spr(tr_wr_spr), .tr_wr_pcm(tr_wr_pcm),
		.tr_wr_z80(tr_wr_z80), .tr_wr_fix(tr_wr_fix)
	);

endmodule

//--- rtl/cd_upload_decode.sv
`timescale 1ns/1ns

module cd_upload_decode
	import cd_host_pkg::*;
	import cd_dma_pkg::*;
(
	input  cpu_bus_t    cpu,
	input  dma_bus_t    dma,
	input  upload_ctl_t upload_ctl,
	output logic        tr_wr_spr,
	output logic        tr_wr_pcm,
	output logic        tr_wr_z80,
	output logic        tr_wr_fix
);

	logic tr_zone, zone_wr;
	logic sel_spr, sel_pcm, sel_z80, sel_fix;

	// DMA owns the upload window while it runs
	assign tr_zone = dma.running ? (dma.addr_out[23:20] == UPLOAD_ZONE) :
	                               (cpu.addr[23:20] == UPLOAD_ZONE);
	assign zone_wr = tr_zone & (dma.running ? dma.wr :
		~cpu.rw & ~(cpu.nlds & cpu.nuds));

	// Area must match and be mapped in
	assign sel_spr = (upload_ctl.area == AREA_SPR) & upload_ctl.use_spr;
	assign sel_pcm = (upload_ctl.area == AREA_PCM) & upload_ctl.use_pcm;
	assign sel_z80 = (upload_ctl.area == AREA_Z80) & upload_ctl.use_z80;
	assign sel_fix = (upload_ctl.area == AREA_FIX) & upload_ctl.use_fix;

	assign tr_wr_spr = zone_wr & sel_spr;
	assign tr_wr_pcm = zone_wr & sel_pcm;
	assign tr_wr_z80 = zone_wr & sel_z80;
	assign tr_wr_fix = zone_wr & sel_fix;

endmodule

//--- verilog.f
rtl/cd_host_pkg.sv
rtl/cd_dma_pkg.sv
rtl/cd_host_regs.sv
rtl/cd_dma_engine.sv
rtl/cd_upload_decode.sv
rtl/cd_sys.sv
dv/cd_sys_checker.sv
dv/tb_cd_sys.sv
